/* verilog/ceres_defines.svh */
// ------------------------------
// word width and divide op codes, shared by rtl and testbench
// ------------------------------

`ifndef CERES_DEFINES_SVH
`define CERES_DEFINES_SVH

// ------------------------------
// data path
// ------------------------------
`define XLEN 32 // rv32 word

// ------------------------------
// op encodings
// ------------------------------
// bit 0 = unsigned, bit 1 = remainder
// same as funct3[1:0] of the M extension
`define DIV_OP_DIV  2'd0 // signed quotient
`define DIV_OP_DIVU 2'd1 // unsigned quotient
`define DIV_OP_REM  2'd2 // signed remainder
`define DIV_OP_REMU 2'd3 // unsigned remainder

`endif

/* verilog/ceres_div_pkg.sv */
// ------------------------------
// types for the divide unit, widths come from `XLEN
// ------------------------------

`default_nettype none

`include "ceres_defines.svh"

package ceres_div_pkg;

  // ------------------------------
  // data types
  // ------------------------------
  typedef logic [`XLEN-1:0] xlen_t;            // one data word
  typedef logic [1:0] div_op_t;                // DIV/DIVU/REM/REMU
  typedef logic [$clog2(`XLEN+1)-1:0] div_count_t; // holds 0..XLEN

  // ------------------------------
  // state machines
  // ------------------------------
  typedef enum logic {
    DIV_IDLE, // waiting for start
    DIV_RUN   // shifting, one bit per clock
  } div_state_e;

  typedef enum logic [1:0] {
    CTRL_IDLE,  // ready for a request
    CTRL_WAIT,  // core working
    CTRL_RESULT // result pulse
  } ctrl_state_e;

endpackage

`default_nettype wire

/* verilog/div_if.sv */
// ------------------------------
// start/done link, one division in flight at a time
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

interface div_if;

  // controller side
  logic                 start;    // one cycle pulse, only while busy is low
  ceres_div_pkg::xlen_t dividend; // unsigned magnitude
  ceres_div_pkg::xlen_t divisor;  // unsigned magnitude

  // core side
  logic                 busy;      // division running
  logic                 done;      // one cycle, results valid here
  logic                 dbz;       // divide by zero, valid with done
  ceres_div_pkg::xlen_t quotient;  // holds until next start
  ceres_div_pkg::xlen_t remainder; // holds until next start

  modport ctrl_mp (
    output start, dividend, divisor,
    input  busy, done, dbz, quotient, remainder
  );

  modport core_mp (
    input  start, dividend, divisor,
    output busy, done, dbz, quotient, remainder
  );

endinterface

`default_nettype wire

/* verilog/divu_int.sv */
// ------------------------------
// restoring divider, done WIDTH+1 clocks after start
// WIDTH >= 2 and not above XLEN (counter and link sized from XLEN)
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ceres_defines.svh"

module divu_int #(
  parameter int WIDTH = `XLEN
) (
  input logic    clk_i,
  input logic    rst_ni,
  div_if.core_mp div_port
);

  ceres_div_pkg::div_state_e state_q;
  ceres_div_pkg::div_count_t count_q; // steps left
  logic                      done_q;
  logic                      dbz_q;

  logic [WIDTH-1:0] divisor_q;
  logic [WIDTH-1:0] quo_q;     // dividend shifts out, quotient shifts in
  logic [WIDTH-1:0] rem_q;     // partial remainder, always below the divisor

  logic             load_en;   // start taken this edge
  logic             zero_div;  // divisor is zero at start
  logic             step_en;   // one shift/subtract this edge
  logic             step_take; // subtract and set quotient bit
  logic [WIDTH:0]   rem_shift; // one spare bit for the compare
  logic [WIDTH:0]   rem_diff;  // trial subtract, top bit is the borrow
  logic [WIDTH-1:0] rem_next;
  logic [WIDTH-1:0] quo_next;

  assign load_en  = (state_q == ceres_div_pkg::DIV_IDLE) && div_port.start;
  assign zero_div = (div_port.divisor == '0);
  assign step_en  = (state_q == ceres_div_pkg::DIV_RUN) && (count_q != '0);

  // ------------------------------
  // one restoring step
  // ------------------------------
  always_comb begin
    rem_shift = {rem_q, quo_q[WIDTH-1]};         // shift pair left
    rem_diff  = rem_shift - {1'b0, divisor_q};
    step_take = ~rem_diff[WIDTH];                // no borrow, divisor fits
    rem_next  = step_take ? rem_diff[WIDTH-1:0] : rem_shift[WIDTH-1:0];
    quo_next  = {quo_q[WIDTH-2:0], step_take};   // new bit in at lsb
  end

  // ------------------------------
  // control
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= ceres_div_pkg::DIV_IDLE;
      count_q <= '0;
      done_q  <= 1'b0;
      dbz_q   <= 1'b0;
    end else begin
      done_q <= 1'b0; // pulses only
      dbz_q  <= 1'b0;
      unique case (state_q)
        ceres_div_pkg::DIV_IDLE: begin
          if (div_port.start) begin
            if (zero_div) begin
              done_q <= 1'b1; // finish right away
              dbz_q  <= 1'b1;
            end else begin
              state_q <= ceres_div_pkg::DIV_RUN;
              count_q <= ceres_div_pkg::div_count_t'(WIDTH);
            end
          end
        end
        ceres_div_pkg::DIV_RUN: begin
          if (count_q != '0) begin
            count_q <= count_q - ceres_div_pkg::div_count_t'(1);
          end else begin
            state_q <= ceres_div_pkg::DIV_IDLE; // all bits done
            done_q  <= 1'b1;
          end
        end
        default: state_q <= ceres_div_pkg::DIV_IDLE;
      endcase
    end
  end

  // ------------------------------
  // data path
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (load_en) begin
      divisor_q <= div_port.divisor;
      if (zero_div) begin
        quo_q <= '0;                // quotient reads zero
        rem_q <= div_port.dividend; // remainder = dividend
      end else begin
        quo_q <= div_port.dividend;
        rem_q <= '0;
      end
    end else if (step_en) begin
      quo_q <= quo_next;
      rem_q <= rem_next;
    end
  end

  assign div_port.busy      = (state_q == ceres_div_pkg::DIV_RUN);
  assign div_port.done      = done_q;
  assign div_port.dbz       = dbz_q;
  assign div_port.quotient  = quo_q; // stable while idle
  assign div_port.remainder = rem_q;

endmodule

`default_nettype wire

/* verilog/div_sign_ctrl.sv */
// ------------------------------
// one request in flight, result pulse has no back-pressure
// DIV then REM (or back) on equal operands is answered from the last result
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ceres_defines.svh"

module div_sign_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    valid_i,
  input  ceres_div_pkg::div_op_t  op_i,
  input  ceres_div_pkg::xlen_t    rs1_i,
  input  ceres_div_pkg::xlen_t    rs2_i,
  output logic                    ready_o,
  output logic                    result_valid_o,
  output ceres_div_pkg::xlen_t    result_o,
  div_if.ctrl_mp                  div_port
);

  ceres_div_pkg::ctrl_state_e state_q;
  logic                       start_q;
  logic                       rec_valid_q; // stored results match op_q/rs1_q/rs2_q

  ceres_div_pkg::div_op_t op_q;
  ceres_div_pkg::xlen_t   rs1_q;      // original operands, for fusion and dbz
  ceres_div_pkg::xlen_t   rs2_q;
  ceres_div_pkg::xlen_t   mag1_q;     // magnitudes sent to the core
  ceres_div_pkg::xlen_t   mag2_q;
  logic                   neg_quo_q;  // operand signs differ
  logic                   neg_rem_q;  // dividend negative
  ceres_div_pkg::xlen_t   quo_res_q;
  ceres_div_pkg::xlen_t   rem_res_q;

  logic                 accept;
  logic                 op_signed;
  logic                 fuse_hit;
  logic                 core_fin;  // core done while waiting
  ceres_div_pkg::xlen_t rs1_mag;
  ceres_div_pkg::xlen_t rs2_mag;

  // ------------------------------
  // request decode
  // ------------------------------
  always_comb begin
    case (op_i)
      `DIV_OP_DIV, `DIV_OP_REM: op_signed = 1'b1;
      default:                  op_signed = 1'b0; // DIVU, REMU
    endcase
  end

  assign ready_o  = (state_q == ceres_div_pkg::CTRL_IDLE);
  assign accept   = valid_i && ready_o;
  assign core_fin = (state_q == ceres_div_pkg::CTRL_WAIT) && div_port.done;
  assign rs1_mag  = (op_signed && rs1_i[`XLEN-1]) ? -rs1_i : rs1_i; // -2^31 stays 2^31
  assign rs2_mag  = (op_signed && rs2_i[`XLEN-1]) ? -rs2_i : rs2_i;

  // same signedness, other half, same operands
  assign fuse_hit = rec_valid_q
                 && (op_i[0] == op_q[0])
                 && (op_i[1] != op_q[1])
                 && (rs1_i == rs1_q)
                 && (rs2_i == rs2_q);

  // ------------------------------
  // control
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q     <= ceres_div_pkg::CTRL_IDLE;
      start_q     <= 1'b0;
      rec_valid_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      unique case (state_q)
        ceres_div_pkg::CTRL_IDLE: begin
          if (accept) begin
            if (fuse_hit) begin
              state_q <= ceres_div_pkg::CTRL_RESULT; // answer next cycle
            end else begin
              state_q     <= ceres_div_pkg::CTRL_WAIT;
              start_q     <= 1'b1;
              rec_valid_q <= 1'b0; // record is being overwritten
            end
          end
        end
        ceres_div_pkg::CTRL_WAIT: begin
          if (div_port.done) begin
            state_q     <= ceres_div_pkg::CTRL_RESULT;
            rec_valid_q <= 1'b1;
          end
        end
        ceres_div_pkg::CTRL_RESULT: state_q <= ceres_div_pkg::CTRL_IDLE;
        default:                    state_q <= ceres_div_pkg::CTRL_IDLE;
      endcase
    end
  end

  // ------------------------------
  // operands and results
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q <= op_i; // fused op picks the other stored result
      if (!fuse_hit) begin
        rs1_q     <= rs1_i;
        rs2_q     <= rs2_i;
        mag1_q    <= rs1_mag;
        mag2_q    <= rs2_mag;
        neg_quo_q <= op_signed && (rs1_i[`XLEN-1] ^ rs2_i[`XLEN-1]);
        neg_rem_q <= op_signed && rs1_i[`XLEN-1]; // remainder follows dividend
      end
    end
    if (core_fin) begin
      if (div_port.dbz) begin
        quo_res_q <= '1;    // x/0 = all ones
        rem_res_q <= rs1_q; // x%0 = x, signed or not
      end else begin
        quo_res_q <= neg_quo_q ? -div_port.quotient : div_port.quotient;
        rem_res_q <= neg_rem_q ? -div_port.remainder : div_port.remainder;
      end
    end
  end

  always_comb begin
    case (op_q)
      `DIV_OP_REM, `DIV_OP_REMU: result_o = rem_res_q;
      default:                   result_o = quo_res_q;
    endcase
  end

  assign result_valid_o    = (state_q == ceres_div_pkg::CTRL_RESULT);
  assign div_port.start    = start_q;
  assign div_port.dividend = mag1_q;
  assign div_port.divisor  = mag2_q;

endmodule

`default_nettype wire

/* verilog/riscv_div_unit.sv */
// ------------------------------
// DIV/DIVU/REM/REMU unit, valid/ready in, one cycle result pulse out
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ceres_defines.svh"

module riscv_div_unit (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // request
  input  logic                   valid_i,
  input  ceres_div_pkg::div_op_t op_i,
  input  ceres_div_pkg::xlen_t   rs1_i,
  input  ceres_div_pkg::xlen_t   rs2_i,
  output logic                   ready_o,  // low while a request is in flight

  // result
  output logic                   result_valid_o, // one cycle
  output ceres_div_pkg::xlen_t   result_o
);

  // ------------------------------
  // controller to core link
  // ------------------------------
  div_if div_bus ();

  // signs, special cases, fusion
  div_sign_ctrl div_sign_ctrl_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .valid_i        (valid_i),
    .op_i           (op_i),
    .rs1_i          (rs1_i),
    .rs2_i          (rs2_i),
    .ready_o        (ready_o),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .div_port       (div_bus)
  );

  // unsigned core, one quotient bit per clock
  divu_int #(
    .WIDTH (`XLEN)
  ) divu_int_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .div_port (div_bus)
  );

endmodule

`default_nettype wire

/* verif/riscv_div_unit_assertions.sv */
// ------------------------------
// handshake checks for the core link and the request port
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module riscv_div_unit_assertions (
  input logic clk_i,
  input logic rst_ni,
  input logic start_i,        // controller to core
  input logic busy_i,
  input logic done_i,
  input logic ready_i,        // request port
  input logic result_valid_i
);

  // done is a pulse, never two cycles in a row
  done_single_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni) done_i |=> !done_i
  ) else $error("done held for more than one cycle");

  // one division at a time
  start_not_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni) start_i |-> !busy_i
  ) else $error("start while the core is busy");

  result_not_ready: assert property (
    @(posedge clk_i) disable iff (!rst_ni) result_valid_i |-> !ready_i
  ) else $error("result pulse while ready is high");

  // port reopens right after the result
  ready_after_result: assert property (
    @(posedge clk_i) disable iff (!rst_ni) result_valid_i |=> ready_i
  ) else $error("ready did not return after the result pulse");

endmodule

// controller sees both the core link and the request port
bind div_sign_ctrl riscv_div_unit_assertions ctrl_sva (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .start_i        (div_port.start),
  .busy_i         (div_port.busy),
  .done_i         (div_port.done),
  .ready_i        (ready_o),
  .result_valid_i (result_valid_o)
);

`default_nettype wire

/* verif/riscv_div_unit_tb.sv */
// ------------------------------
// random and directed DIV/REM requests, one in flight, checked in order
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ceres_defines.svh"

module riscv_div_unit_tb;

  localparam int NUM_RAND    = 40;                     // per signedness
  localparam int NUM_REQ     = 2 * NUM_RAND + 20;      // all requests sent
  localparam int TIMEOUT_CYC = NUM_REQ * (`XLEN + 8) + 200;

  logic                   clk;
  logic                   rst_n;
  logic                   valid;
  ceres_div_pkg::div_op_t op;
  ceres_div_pkg::xlen_t   rs1;
  ceres_div_pkg::xlen_t   rs2;
  logic                   ready;
  logic                   result_valid;
  ceres_div_pkg::xlen_t   result;

  int seed       = 32'hd76e7b64;
  int cycle      = 0;
  int accept_cnt = 0;
  int result_cnt = 0;

  ceres_div_pkg::xlen_t exp_q[$];   // expected results, in request order
  bit                   fused_q[$]; // request should be answered from the record
  int                   acc_q[$];   // cycle of acceptance

  riscv_div_unit riscv_div_unit_inst (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .valid_i        (valid),
    .op_i           (op),
    .rs1_i          (rs1),
    .rs2_i          (rs2),
    .ready_o        (ready),
    .result_valid_o (result_valid),
    .result_o       (result)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  always @(posedge clk) cycle <= cycle + 1;

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic ceres_div_pkg::xlen_t ref_div(input ceres_div_pkg::div_op_t f_op,
                                                   input ceres_div_pkg::xlen_t   a,
                                                   input ceres_div_pkg::xlen_t   b);
    ceres_div_pkg::xlen_t min_int;
    logic                 is_uns;
    logic                 is_rem;
    min_int = {1'b1, {(`XLEN-1){1'b0}}};
    is_uns  = f_op[0];
    is_rem  = f_op[1];
    if (b == '0) return is_rem ? a : '1;                      // divide by zero
    if (!is_uns && a == min_int && b == '1) return is_rem ? '0 : min_int; // overflow
    if (is_uns) return is_rem ? a % b : a / b;
    // signed ops truncate toward zero, remainder follows the dividend
    return is_rem ? ceres_div_pkg::xlen_t'($signed(a) % $signed(b))
                  : ceres_div_pkg::xlen_t'($signed(a) / $signed(b));
  endfunction

  // random word shifted right by a random amount, so quotients vary in size
  function automatic ceres_div_pkg::xlen_t rand_divisor();
    ceres_div_pkg::xlen_t w;
    w = $random(seed);
    return w >> ($random(seed) & 31);
  endfunction

  // ------------------------------
  // checks
  // ------------------------------
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_result(input ceres_div_pkg::xlen_t exp_val,
                              input ceres_div_pkg::xlen_t act_val);
    if (act_val !== exp_val)
      stop_with_failure($sformatf("[FAIL] %0t ns result_o expected %08h got %08h",
                                  $time, exp_val, act_val));
  endtask

  task automatic check_ready(input logic exp_val, input logic act_val);
    if (act_val !== exp_val)
      stop_with_failure($sformatf("[FAIL] %0t ns ready_o expected %0b got %0b",
                                  $time, exp_val, act_val));
  endtask

  task automatic check_fused_latency(input int exp_cyc, input int act_cyc);
    if (act_cyc != exp_cyc)
      stop_with_failure($sformatf("[FAIL] %0t ns result_valid_o latency expected %0d got %0d",
                                  $time, exp_cyc, act_cyc));
  endtask

  // ------------------------------
  // request driver
  // ------------------------------
  // hold keeps valid high for that many cycles after acceptance
  task automatic send_req(input ceres_div_pkg::div_op_t r_op,
                          input ceres_div_pkg::xlen_t   a,
                          input ceres_div_pkg::xlen_t   b,
                          input bit                     fused,
                          input int                     hold);
    @(negedge clk);
    valid = 1'b1;
    op    = r_op;
    rs1   = a;
    rs2   = b;
    while (!ready) @(negedge clk); // ready is stable at the falling edge
    exp_q.push_back(ref_div(r_op, a, b));
    fused_q.push_back(fused);
    acc_q.push_back(cycle);
    accept_cnt++;
    repeat (hold) begin
      @(negedge clk);
      check_ready(1'b0, ready);    // port stays closed while busy
      rs1 = $random(seed);         // junk while busy, must be ignored
      rs2 = $random(seed);
    end
    @(negedge clk);
    valid = 1'b0;
  endtask

  // compare process, outputs sampled on the falling edge
  initial begin
    ceres_div_pkg::xlen_t exp_val;
    bit                   was_fused;
    int                   acc_cyc;
    forever begin
      @(negedge clk);
      if (rst_n && result_valid) begin
        if (exp_q.size() == 0) begin
          stop_with_failure("result pulse arrived with no accepted request pending");
        end else begin
          exp_val   = exp_q.pop_front();
          was_fused = fused_q.pop_front();
          acc_cyc   = acc_q.pop_front();
          result_cnt++;
          check_result(exp_val, result);
          if (was_fused) check_fused_latency(1, cycle - acc_cyc);
        end
      end
    end
  end

  // watchdog
  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk);
    stop_with_failure($sformatf("no result arrived within %0d cycles", TIMEOUT_CYC));
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    ceres_div_pkg::xlen_t   a;
    ceres_div_pkg::xlen_t   b;
    ceres_div_pkg::xlen_t   min_int;
    ceres_div_pkg::div_op_t first_op;
    valid   = 1'b0;
    op      = `DIV_OP_DIV;
    rs1     = '0;
    rs2     = '0;
    rst_n   = 1'b0;
    min_int = {1'b1, {(`XLEN-1){1'b0}}};
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // unsigned DIVU and REMU
    for (int i = 0; i < NUM_RAND; i++) begin
      a = $random(seed);
      b = rand_divisor();
      send_req(i[0] ? `DIV_OP_REMU : `DIV_OP_DIVU, a, b, 1'b0, 0);
    end

    // signed DIV and REM, i[2:1] walks the four sign combinations
    for (int i = 0; i < NUM_RAND; i++) begin
      a = ceres_div_pkg::xlen_t'($random(seed)) >> 1;
      b = rand_divisor() >> 1;
      a = i[1] ? -a : a;
      b = i[2] ? -b : b;
      send_req(i[0] ? `DIV_OP_REM : `DIV_OP_DIV, a, b, 1'b0, 0);
    end

    // divide by zero, every op, both dividend signs
    for (int i = 0; i < 8; i++) begin
      a = $random(seed);
      a[`XLEN-1] = i[2];
      send_req(ceres_div_pkg::div_op_t'(i[1:0]), a, '0, 1'b0, 0);
    end

    // signed overflow, the REM reuses the DIV result
    send_req(`DIV_OP_DIV, min_int, '1, 1'b0, 0);
    send_req(`DIV_OP_REM, min_int, '1, 1'b1, 0);

    // fused pairs in both orders, signed and unsigned
    for (int i = 0; i < 4; i++) begin
      a        = $random(seed);
      b        = rand_divisor();
      first_op = ceres_div_pkg::div_op_t'({i[0], i[1]}); // bit 1 rem, bit 0 unsigned
      send_req(first_op, a, b, 1'b0, 0);
      send_req(first_op ^ 2'b10, a, b, 1'b1, 0);
    end

    // valid held high while busy
    for (int i = 0; i < 2; i++) begin
      a = $random(seed);
      b = rand_divisor() | 1; // nonzero, core stays busy past the hold
      send_req(`DIV_OP_DIVU, a, b, 1'b0, 8);
    end

    while (exp_q.size() != 0) @(negedge clk);
    repeat (`XLEN + 8) @(negedge clk); // room for a stray extra result
    if (result_cnt == accept_cnt) begin
      $display("TEST OK");
      $finish;
    end else begin
      stop_with_failure($sformatf("%0d results for %0d accepted requests",
                                  result_cnt, accept_cnt));
    end
  end

endmodule

`default_nettype wire

/* riscv_div_unit.f */
+incdir+verilog
verilog/ceres_div_pkg.sv
verilog/div_if.sv
verilog/divu_int.sv
verilog/div_sign_ctrl.sv
verilog/riscv_div_unit.sv
verif/riscv_div_unit_assertions.sv
verif/riscv_div_unit_tb.sv

/* Makefile */
# Verilator build and run for the divide unit

VERILATOR ?= verilator
TOP       := riscv_div_unit_tb
RTL_TOP   := riscv_div_unit
FILELIST  := riscv_div_unit.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TEST OK
VFLAGS    := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
